// File: lookahead_router.sv
`timescale 1ns/1ps

module lookahead_router (
  input  logic                                    clk,
  input  logic                                    rst,
  input  noc_pkg::xy_t                            position_i,
  input  noc_pkg::link_t [noc_pkg::num_ports-1:0] link_i,
  output noc_pkg::port_vec_t                      stop_o,
  output noc_pkg::link_t [noc_pkg::num_ports-1:0] link_o,
  input  noc_pkg::port_vec_t                      stop_i
);
  import noc_pkg::*;

  // Queue heads, seen by every output
  in_head_t [num_ports-1:0]  heads;
  // Pops grouped by output
  port_vec_t [num_ports-1:0] pop_out;
  // Same pops grouped by input
  port_vec_t [num_ports-1:0] pop_in;

  ////////////////////////////////////////
  // Pop regrouping
  ////////////////////////////////////////

  for (genvar o = 0; o < num_ports; o++) begin : gen_pop_out
    for (genvar i = 0; i < num_ports; i++) begin : gen_pop_in
      assign pop_in[i][o] = pop_out[o][i];
    end
  end

  ////////////////////////////////////////
  // Ports
  ////////////////////////////////////////

  for (genvar g = 0; g < num_ports; g++) begin : gen_input
    router_input_port u_in (
      .clk        (clk),
      .rst        (rst),
      .position_i (position_i),
      .link_i     (link_i[g]),
      .pop_i      (pop_in[g]),
      .stop_o     (stop_o[g]),
      .head_o     (heads[g])
    );
  end

  for (genvar g = 0; g < num_ports; g++) begin : gen_output
    router_output_port #(
      .port_idx (g)
    ) u_out (
      .clk     (clk),
      .rst     (rst),
      .heads_i (heads),
      .stop_i  (stop_i[g]),
      .pop_o   (pop_out[g]),
      .link_o  (link_o[g])
    );
  end

endmodule

// File: noc_pkg.sv
package noc_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // One mesh coordinate
  localparam int coord_width = 3;
  localparam int message_width = 5;
  // One-hot direction field
  localparam int route_width = 5;
  // Flit body without the preamble
  localparam int data_width = 32;
  // Left over after both coordinate pairs, message and route
  localparam int reserved_width = data_width - 4 * coord_width - message_width - route_width;
  localparam int num_ports = 5;

  // Input queue
  localparam int queue_depth = 4;
  localparam int ptr_width = 2;

  ////////////////////////////////////////
  // Ports and directions
  ////////////////////////////////////////

  localparam int port_north = 0;
  localparam int port_south = 1;
  localparam int port_west = 2;
  localparam int port_east = 3;
  localparam int port_local = 4;

  // One-hot code with the bit at the matching port index
  localparam logic [route_width-1:0] go_north = route_width'(1) << port_north;
  localparam logic [route_width-1:0] go_south = route_width'(1) << port_south;
  localparam logic [route_width-1:0] go_west = route_width'(1) << port_west;
  localparam logic [route_width-1:0] go_east = route_width'(1) << port_east;
  localparam logic [route_width-1:0] go_local = route_width'(1) << port_local;

  typedef logic [num_ports-1:0] port_vec_t;

  ////////////////////////////////////////
  // Flit and link types
  ////////////////////////////////////////

  // x grows eastward, y grows southward
  typedef struct packed {
    logic [coord_width-1:0] x;
    logic [coord_width-1:0] y;
  } xy_t;

  // Single-flit packet has both bits set
  typedef struct packed {
    logic head;
    logic tail;
  } preamble_t;

  typedef struct packed {
    preamble_t preamble;
    xy_t source;
    xy_t destination;
    logic [message_width-1:0] message;
    logic [reserved_width-1:0] reserved;
    // Direction taken at the router that receives this flit
    logic [route_width-1:0] route;
  } header_t;

  typedef union packed {
    header_t header;
    logic [data_width+$bits(preamble_t)-1:0] raw;
  } flit_t;

  // data_void high when no flit is on the wire
  typedef struct packed {
    flit_t flit;
    logic data_void;
  } link_t;

  // Queue head as seen by every output
  typedef struct packed {
    flit_t flit;
    port_vec_t next_route;
    logic data_void;
    port_vec_t request;
  } in_head_t;

endpackage

// File: router_fifo.sv
`timescale 1ns/1ps

module router_fifo (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr_i,
  input  logic           rd_i,
  input  noc_pkg::flit_t data_i,
  output noc_pkg::flit_t data_o,
  output logic           empty_o,
  output logic           full_o
);
  import noc_pkg::*;

  flit_t                mem [queue_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 push;
  logic                 pop;

  // Flit read in the same cycle it arrives at an empty queue is not stored
  assign push = wr_i & ~full_o & ~(empty_o & rd_i);
  // Only a stored flit moves the read pointer
  assign pop = rd_i & ~empty_o;

  assign empty_o = (count == '0);
  assign full_o = (count == (ptr_width + 1)'(queue_depth));

  // Empty queue shows the incoming flit directly
  assign data_o = empty_o ? data_i : mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // Circular pointers and occupancy count
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Sender upstream must respect stop_o
  a_no_write_full: assert property (@(posedge clk) disable iff (rst) full_o |-> !wr_i)
    else $error("router_fifo: write while full");

endmodule

// File: router_input.dat
# batch pos_x pos_y in_port dest_x dest_y length stall_mask stall_cycles
# ports: 0 north, 1 south, 2 west, 3 east, 4 local; stall_mask has one bit per output
1 3 3 2 6 3 4 0 0
2 3 3 0 3 6 3 0 0
3 2 5 3 2 5 1 0 0
4 5 1 4 1 4 5 0 0
5 4 4 2 7 2 4 0 0
5 4 4 4 6 6 3 0 0
5 4 4 1 5 0 2 0 0
6 1 1 4 1 0 7 1 12
7 6 2 0 6 2 2 0 0
7 6 2 3 6 2 1 0 0
8 0 0 4 1 3 2 0 0
9 2 2 2 2 4 6 2 10
9 2 2 3 2 7 3 2 10

// File: router_input_port.sv
`timescale 1ns/1ps

module router_input_port (
  input  logic               clk,
  input  logic               rst,
  input  noc_pkg::xy_t       position_i,
  input  noc_pkg::link_t     link_i,
  input  noc_pkg::port_vec_t pop_i,
  output logic               stop_o,
  output noc_pkg::in_head_t  head_o
);
  import noc_pkg::*;

  flit_t     fifo_head;
  logic      empty;
  logic      full;
  logic      rd;
  logic      in_void;
  logic      valid_head;
  logic      valid_tail;
  port_vec_t saved_request;
  port_vec_t next_route;

  ////////////////////////////////////////
  // Queue
  ////////////////////////////////////////

  // At most one output pops at a time
  assign rd = |pop_i;

  router_fifo u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_i    (~link_i.data_void),
    .rd_i    (rd),
    .data_i  (link_i.flit),
    .data_o  (fifo_head),
    .empty_o (empty),
    .full_o  (full)
  );

  // Nothing stored and nothing bypassing
  assign in_void = empty & link_i.data_void;
  assign valid_head = fifo_head.header.preamble.head & ~in_void;
  assign valid_tail = fifo_head.header.preamble.tail & ~in_void;

  // Back-pressure toward the sender
  assign stop_o = full;

  ////////////////////////////////////////
  // Worm request and look-ahead
  ////////////////////////////////////////

  // Held over body flits and dropped once the tail reaches the queue head
  always_ff @(posedge clk) begin
    if (rst) begin
      saved_request <= '0;
    end else if (valid_tail) begin
      saved_request <= '0;
    end else if (valid_head) begin
      saved_request <= fifo_head.header.route;
    end
  end

  // Direction the next router takes
  xy_lookahead_route u_route (
    .position_i    (position_i),
    .route_i       (fifo_head.header.route),
    .destination_i (fifo_head.header.destination),
    .next_route_o  (next_route)
  );

  always_comb begin
    head_o.flit = fifo_head;
    head_o.next_route = next_route;
    head_o.data_void = in_void;
    // Fresh head requests straight from its route field
    head_o.request = valid_head ? fifo_head.header.route : saved_request;
  end

endmodule

// File: router_output_port.sv
`timescale 1ns/1ps

module router_output_port #(
  parameter int port_idx = 0
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  noc_pkg::in_head_t [noc_pkg::num_ports-1:0] heads_i,
  input  logic                                       stop_i,
  output noc_pkg::port_vec_t                         pop_o,
  output noc_pkg::link_t                             link_o
);
  import noc_pkg::*;

  typedef enum logic {
    head_st    = 1'b0,
    payload_st = 1'b1
  } state_t;

  state_t               state_q;
  state_t               state_d;
  logic [num_ports-2:0] req_col;
  logic [num_ports-2:0] grant;
  logic                 grant_valid;
  port_vec_t            grant_port;
  port_vec_t            cfg_q;
  port_vec_t            conn;
  in_head_t             sel;
  flit_t                out_flit;
  logic                 fwd_valid;
  logic                 head_fwd;
  logic                 tail_fwd;
  flit_t                data_q;
  logic                 void_q;

  ////////////////////////////////////////
  // Request column and arbitration
  ////////////////////////////////////////

  // Own input is skipped since a worm never turns back
  always_comb begin
    for (int k = 0; k < num_ports - 1; k++) begin
      if (k < port_idx) begin
        req_col[k] = heads_i[k].request[port_idx];
      end else begin
        req_col[k] = heads_i[k+1].request[port_idx];
      end
    end
  end

  rr_arbiter u_arb (
    .clk           (clk),
    .rst           (rst),
    .request_i     (req_col),
    .head_fwd_i    (head_fwd),
    .tail_fwd_i    (tail_fwd),
    .grant_o       (grant),
    .grant_valid_o (grant_valid)
  );

  // Grant back onto input indices
  always_comb begin
    grant_port = '0;
    for (int k = 0; k < num_ports - 1; k++) begin
      if (k < port_idx) begin
        grant_port[k] = grant[k];
      end else begin
        grant_port[k+1] = grant[k];
      end
    end
  end

  ////////////////////////////////////////
  // Worm FSM and crossbar
  ////////////////////////////////////////

  // New winner only between worms and the saved connection inside one
  always_comb begin
    if (state_q == payload_st) begin
      conn = cfg_q;
    end else if (grant_valid && !stop_i) begin
      conn = grant_port;
    end else begin
      conn = '0;
    end
  end

  // No connection reads as void
  always_comb begin
    sel = '0;
    sel.data_void = 1'b1;
    for (int p = 0; p < num_ports; p++) begin
      if (conn[p]) begin
        sel = heads_i[p];
      end
    end
  end

  assign fwd_valid = ~sel.data_void & ~stop_i;
  assign head_fwd = fwd_valid & sel.flit.header.preamble.head;
  assign tail_fwd = fwd_valid & sel.flit.header.preamble.tail;

  // Pop only the input whose flit leaves this cycle
  assign pop_o = fwd_valid ? conn : '0;

  // First flit of a worm carries the next router's direction
  always_comb begin
    out_flit = sel.flit;
    if (state_q == head_st) begin
      out_flit.raw = {sel.flit.raw[$bits(flit_t)-1:route_width], sel.next_route};
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      head_st: begin
        // Multi-flit worm locks the connection
        if (fwd_valid && !sel.flit.header.preamble.tail) begin
          state_d = payload_st;
        end
      end
      payload_st: begin
        if (tail_fwd) begin
          state_d = head_st;
        end
      end
      default: state_d = head_st;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= head_st;
      cfg_q <= '0;
      void_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if ((state_q == head_st) && fwd_valid) begin
        cfg_q <= conn;
      end
      // Stall freezes the void flag too
      if (!stop_i) begin
        void_q <= ~fwd_valid;
      end
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fwd_valid) begin
      data_q <= out_flit;
    end
  end

  assign link_o = '{flit: data_q, data_void: void_q};

  // A connection opens only on a head flit
  a_head_opens: assert property (@(posedge clk) disable iff (rst)
    ((state_q == head_st) && fwd_valid) |-> sel.flit.header.preamble.head)
    else $error("router_output_port: worm opened by a body flit");

  // Worm body follows the same input as its head
  a_body_only: assert property (@(posedge clk) disable iff (rst)
    ((state_q == payload_st) && !sel.data_void) |-> !sel.flit.header.preamble.head)
    else $error("router_output_port: head flit inside a worm");

endmodule

// File: rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [noc_pkg::num_ports-2:0] request_i,
  input  logic                          head_fwd_i,
  input  logic                          tail_fwd_i,
  output logic [noc_pkg::num_ports-2:0] grant_o,
  output logic                          grant_valid_o
);
  import noc_pkg::*;

  // Winner of the last finished worm
  logic [1:0] last_q;
  // Winner of the worm in flight
  logic [1:0] owner_q;
  logic [1:0] grant_idx;

  // First requester after the last winner in rotating order
  always_comb begin
    logic [1:0] idx;
    grant_o = '0;
    grant_idx = '0;
    for (int i = 1; i <= num_ports - 1; i++) begin
      idx = last_q + 2'(i);
      if (request_i[idx] && (grant_o == '0)) begin
        grant_o[idx] = 1'b1;
        grant_idx = idx;
      end
    end
  end

  assign grant_valid_o = |grant_o;

  // Rotation moves only on a tail, so a worm keeps its grant
  always_ff @(posedge clk) begin
    if (rst) begin
      last_q <= 2'd3;
      owner_q <= '0;
    end else begin
      if (head_fwd_i) begin
        owner_q <= grant_idx;
      end
      if (tail_fwd_i) begin
        // Single-flit worm has head and tail together
        last_q <= head_fwd_i ? grant_idx : owner_q;
      end
    end
  end

  // A worm starts only on a granted input
  a_head_granted: assert property (@(posedge clk) disable iff (rst)
    head_fwd_i |-> grant_valid_o)
    else $error("rr_arbiter: head forwarded without a grant");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_router -f sources.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_router > "$log" 2>&1
sim_status=$?
cat "$log"

if grep -q "test failed" "$log"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: sources.f
noc_pkg.sv
router_fifo.sv
xy_lookahead_route.sv
router_input_port.sv
rr_arbiter.sv
router_output_port.sv
lookahead_router.sv
tb_clock_gen.sv
tb_router.sv

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 16 rising edges, released just after the last one
  initial begin
    rst_o = 1'b1;
    repeat (16) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

// File: tb_router.sv
`timescale 1ns/1ps

module tb_router;
  import noc_pkg::*;

  // One line of the stimulus file
  typedef struct packed {
    int  batch;
    xy_t here;
    int  port;
    int  out;
    int  len;
    int  mask;
    int  stall;
    int  base;
  } packet_t;

  logic                  clk;
  logic                  rst;
  xy_t                   position_i;
  link_t [num_ports-1:0] link_i;
  port_vec_t             stop_o;
  link_t [num_ports-1:0] link_o;
  port_vec_t             stop_i;

  packet_t pkts[$];
  int      sent_cnt[$];
  int      rcv_cnt[$];
  // Flits sent when stop_o first rose or -1 if it never did
  int      stop_at[$];
  bit      lone[$];
  // Flits of all packets in one flat list indexed from each packet's base
  flit_t   sent_q[$];
  flit_t   exp_q[$];
  int      send_cyc[$];

  // Worm currently arriving on each output or -1 when idle
  int                    current [num_ports];
  port_vec_t             stop_q = '0;
  link_t [num_ports-1:0] prev_link;
  int                    cycle = 0;
  int                    limit = 1000000;

  tb_clock_gen u_clk (
    .clk_o (clk),
    .rst_o (rst)
  );

  lookahead_router u_dut (
    .clk        (clk),
    .rst        (rst),
    .position_i (position_i),
    .link_i     (link_i),
    .stop_o     (stop_o),
    .link_o     (link_o),
    .stop_i     (stop_i)
  );

  ////////////////////////////////////////
  // Routing rules
  ////////////////////////////////////////

  // XY order with x before y and local last
  function automatic port_vec_t xy_dir(input xy_t here, input xy_t dest);
    if (dest.x != here.x) begin
      return (dest.x > here.x) ? go_east : go_west;
    end
    if (dest.y != here.y) begin
      return (dest.y > here.y) ? go_south : go_north;
    end
    return go_local;
  endfunction

  // Neighbor position with y growing southward
  function automatic xy_t hop(input xy_t here, input port_vec_t dir);
    xy_t nxt;
    nxt = here;
    case (dir)
      go_north: nxt.y = here.y - 3'd1;
      go_south: nxt.y = here.y + 3'd1;
      go_west:  nxt.x = here.x - 3'd1;
      go_east:  nxt.x = here.x + 3'd1;
      default:  nxt = here;
    endcase
    return nxt;
  endfunction

  function automatic int port_index(input port_vec_t dir);
    case (dir)
      go_north: return port_north;
      go_south: return port_south;
      go_west:  return port_west;
      go_east:  return port_east;
      go_local: return port_local;
      default:  return -1;
    endcase
  endfunction

  task automatic compare_values(input logic [63:0] got, input logic [63:0] expected,
                                input string what);
    if (got !== expected) begin
      $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, got, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus file
  ////////////////////////////////////////

  task automatic read_packets();
    int        fd;
    int        n;
    int        bt, px, py, pt, dx, dy, ln, mk, sl;
    string     line;
    packet_t   pk;
    flit_t     f;
    port_vec_t dir;
    xy_t       dest;
    fd = $fopen("router_input.dat", "r");
    if (fd == 0) begin
      $display("could not open router_input.dat");
      $display("test failed");
      $fatal(1);
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Skip blank and comment lines
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%d %d %d %d %d %d %d %d %d", bt, px, py, pt, dx, dy, ln, mk, sl);
          if (n == 9) begin
            pk.batch = bt;
            pk.here.x = 3'(px);
            pk.here.y = 3'(py);
            pk.port = pt;
            dest.x = 3'(dx);
            dest.y = 3'(dy);
            // Route field names the direction taken here
            dir = xy_dir(pk.here, dest);
            pk.out = port_index(dir);
            pk.len = ln;
            pk.mask = mk;
            pk.stall = sl;
            pk.base = sent_q.size();
            pkts.push_back(pk);
            sent_cnt.push_back(0);
            rcv_cnt.push_back(0);
            stop_at.push_back(-1);
            lone.push_back(1'b0);
            f = '0;
            f.header.preamble.head = 1'b1;
            f.header.preamble.tail = (ln == 1);
            f.header.source.x = 3'($urandom());
            f.header.source.y = 3'($urandom());
            f.header.destination = dest;
            f.header.message = 5'($urandom());
            f.header.reserved = 10'($urandom());
            f.header.route = dir;
            sent_q.push_back(f);
            // Leaves with the next router's direction
            f.header.route = xy_dir(hop(pk.here, dir), dest);
            exp_q.push_back(f);
            send_cyc.push_back(0);
            // Body flits pass untouched
            for (int i = 1; i < ln; i++) begin
              f.raw = {1'b0, (i == ln - 1), $urandom()};
              sent_q.push_back(f);
              exp_q.push_back(f);
              send_cyc.push_back(0);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // Driver
  ////////////////////////////////////////

  // All packets of one batch start together
  task automatic run_batch(input int first, input int last);
    int         k;
    int         j;
    int         idx;
    logic [2:0] pi;
    bit         done;
    position_i = pkts[first].here;
    for (j = first; j <= last; j++) begin
      lone[j] = (first == last) && (pkts[first].mask == 0);
    end
    k = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      #1;
      // Stall window opens with the batch
      stop_i = (k < pkts[first].stall) ? 5'(pkts[first].mask) : '0;
      done = 1'b1;
      for (j = first; j <= last; j++) begin
        pi = 3'(pkts[j].port);
        link_i[pi].data_void = 1'b1;
        if (sent_cnt[j] < pkts[j].len) begin
          done = 1'b0;
          if (stop_o[pi]) begin
            // Input queue is full so the next flit waits
            if (stop_at[j] < 0) begin
              stop_at[j] = sent_cnt[j];
            end
          end else begin
            idx = pkts[j].base + sent_cnt[j];
            link_i[pi].flit = sent_q[idx];
            link_i[pi].data_void = 1'b0;
            send_cyc[idx] = cycle;
            sent_cnt[j] = sent_cnt[j] + 1;
          end
        end else if (rcv_cnt[j] < pkts[j].len) begin
          done = 1'b0;
        end
      end
      k++;
    end
    stop_i = '0;
    // A long stall on the worm's own output fills the queue
    for (j = first; j <= last; j++) begin
      if (pkts[j].len > queue_depth && ((pkts[j].mask >> pkts[j].out) & 1) == 1 &&
          pkts[j].stall >= pkts[j].len + 2) begin
        compare_values(64'(stop_at[j]), 64'(queue_depth), "flits queued when stop_o rose");
      end
    end
  endtask

  ////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////

  task automatic take_flit(input int p, input flit_t got);
    int j;
    int idx;
    // On an idle output the flit must open a waiting worm
    if (current[3'(p)] < 0) begin
      for (j = 0; j < pkts.size(); j++) begin
        if (pkts[j].out == p && sent_cnt[j] > 0 && rcv_cnt[j] == 0 &&
            exp_q[pkts[j].base] == got) begin
          current[3'(p)] = j;
        end
      end
    end
    if (current[3'(p)] < 0) begin
      $display("output %0d delivered flit %h that starts no waiting worm", p, got.raw);
      $display("test failed");
      $fatal(1);
    end else begin
      j = current[3'(p)];
      idx = pkts[j].base + rcv_cnt[j];
      compare_values(64'(got), 64'(exp_q[idx]),
                     $sformatf("flit %0d of worm %0d on output %0d", rcv_cnt[j], j, p));
      if (lone[j]) begin
        compare_values(64'(cycle), 64'(send_cyc[idx] + 1),
                       $sformatf("latency of flit %0d of worm %0d", rcv_cnt[j], j));
      end
      rcv_cnt[j] = rcv_cnt[j] + 1;
      if (rcv_cnt[j] == pkts[j].len) begin
        current[3'(p)] = -1;
      end
    end
  endtask

  // Counts cycles, records the stall seen by the DUT and enforces the run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    stop_q <= stop_i;
    if (cycle >= limit) begin
      $display("timeout: no end of the run after %0d cycles", limit);
      $display("test failed");
      $fatal(1);
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < num_ports; p++) begin
        if (stop_q[3'(p)]) begin
          compare_values(64'(link_o[3'(p)]), 64'(prev_link[3'(p)]),
                         $sformatf("link_o[%0d] under stall", p));
        end else if (!link_o[3'(p)].data_void) begin
          take_flit(p, link_o[3'(p)].flit);
        end
      end
    end
    prev_link = link_o;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int first;
    int last;
    position_i = '0;
    stop_i = '0;
    for (int p = 0; p < num_ports; p++) begin
      link_i[3'(p)].flit = '0;
      link_i[3'(p)].data_void = 1'b1;
      current[3'(p)] = -1;
    end
    void'($urandom(32'h7184f462));
    read_packets();
    limit = 30 * sent_q.size() + 200;
    @(negedge rst);
    @(negedge clk);
    // Idle links out of reset
    compare_values(64'(stop_o), 64'(0), "stop_o after reset");
    for (int p = 0; p < num_ports; p++) begin
      compare_values(64'(link_o[3'(p)].data_void), 64'(1),
                     $sformatf("link_o[%0d] data_void after reset", p));
    end
    first = 0;
    while (first < pkts.size()) begin
      last = first;
      while (last + 1 < pkts.size() && pkts[last+1].batch == pkts[first].batch) begin
        last++;
      end
      run_batch(first, last);
      first = last + 1;
    end
    // Quiet tail to catch stray flits
    repeat (4) @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

// File: xy_lookahead_route.sv
`timescale 1ns/1ps

module xy_lookahead_route (
  input  noc_pkg::xy_t       position_i,
  input  noc_pkg::port_vec_t route_i,
  input  noc_pkg::xy_t       destination_i,
  output noc_pkg::port_vec_t next_route_o
);
  import noc_pkg::*;

  // Position of the router one hop ahead
  xy_t next_pos;

  // Step one hop along the current direction
  always_comb begin
    next_pos = position_i;
    if (route_i[port_north]) begin
      next_pos.y = position_i.y - 1'b1;
    end else if (route_i[port_south]) begin
      next_pos.y = position_i.y + 1'b1;
    end else if (route_i[port_west]) begin
      next_pos.x = position_i.x - 1'b1;
    end else if (route_i[port_east]) begin
      next_pos.x = position_i.x + 1'b1;
    end
    // Local leaves the position where it is
  end

  // Dimension order with x before y and local last
  always_comb begin
    if (destination_i.x > next_pos.x) begin
      next_route_o = go_east;
    end else if (destination_i.x < next_pos.x) begin
      next_route_o = go_west;
    end else if (destination_i.y > next_pos.y) begin
      next_route_o = go_south;
    end else if (destination_i.y < next_pos.y) begin
      next_route_o = go_north;
    end else begin
      next_route_o = go_local;
    end
  end

endmodule
